/* hdl/e31x_board_pkg.sv */
//////////////////////////////
// Board status word and interrupt vector layout,
// plus synchronizer and pulse-stretch lengths for bus_clk logic
//////////////////////////////

package e31x_board_pkg;

  //////////////////////////////
  // Word types
  //////////////////////////////

  // Daughterboard status word read by software
  typedef logic [31:0] status_word_t;

  // Fabric to processor interrupt lines
  typedef logic [15:0] irq_vec_t;

  // Reference status, high to low:
  // PLL locked, 10 MHz present, PPS present, reference locked
  typedef logic [3:0] ref_status_t;

  //////////////////////////////
  // Status word fields
  //////////////////////////////

  // Reference status occupies bits 11:8
  localparam int STAT_REF_LSB     = 8;
  // RF PLL lock levels
  localparam int STAT_TX_LOCK_BIT = 7;
  localparam int STAT_RX_LOCK_BIT = 6;

  //////////////////////////////
  // Interrupt vector bits
  //////////////////////////////

  localparam int IRQ_PRESS_BIT    = 1;
  localparam int IRQ_RELEASE_BIT  = 2;
  // Power-management controller interrupt
  localparam int IRQ_PMU_BIT      = 3;

  //////////////////////////////
  // Timing
  //////////////////////////////

  // Flop depth for status and lock levels
  localparam int SYNC_STAGES      = 2;
  // Delay depth for the GPS pulse-per-second
  localparam int PPS_STAGES       = 3;
  // Button interrupt length in cycles
  localparam int STRETCH_LEN      = 8;

endpackage

/* hdl/e31x_frontend_pkg.sv */
//////////////////////////////
// Field layout of a channel's front-end GPIO and LED words
//////////////////////////////

package e31x_frontend_pkg;

  //////////////////////////////
  // Word and field types
  //////////////////////////////

  // Per-channel front-end control word
  typedef logic [15:0] fe_gpio_t;

  // Filter bank selects
  typedef logic [2:0] bandsel3_t;
  typedef logic [1:0] bandsel2_t;

  // Per-channel LED word
  typedef logic [2:0] fe_led_t;

  //////////////////////////////
  // GPIO word fields
  //////////////////////////////

  // Band selects, widths from the types above
  localparam int FE_TX_BANDSEL_LSB  = 0;
  localparam int FE_RX_BANDSEL_LSB  = 3;
  localparam int FE_RXB_BANDSEL_LSB = 6;
  localparam int FE_RXC_BANDSEL_LSB = 8;

  // Transmit amplifier enables
  localparam int FE_TX_EN_A_BIT     = 10;
  localparam int FE_TX_EN_B_BIT     = 11;

  // Antenna switch controls
  localparam int FE_VCTXRX_V2_BIT   = 12;
  localparam int FE_VCTXRX_V1_BIT   = 13;
  localparam int FE_VCRX_V2_BIT     = 14;
  localparam int FE_VCRX_V1_BIT     = 15;

  //////////////////////////////
  // LED word bits
  //////////////////////////////

  localparam int LED_TXRX_RX_BIT    = 0;
  localparam int LED_TXRX_TX_BIT    = 1;
  localparam int LED_RX_RX_BIT      = 2;

endpackage

/* hdl/status_sync.sv */
//////////////////////////////
// Brings reference status, PLL locks and GPS PPS into bus_clk
//////////////////////////////

`timescale 1ns/1ps

module status_sync
  import e31x_board_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  // Levels from other clock domains
  input  ref_status_t i_ref_status,
  input  logic        i_tx_pll_lock,
  input  logic        i_rx_pll_lock,
  input  logic        i_gps_pps,
  // Resynchronized levels
  output ref_status_t o_ref_status,
  output logic        o_tx_pll_lock,
  output logic        o_rx_pll_lock,
  // PPS for the processor GPIO bit
  output logic        o_pps_gpio
);

  // Flop chains, index 0 samples the input
  ref_status_t            ref_sync [SYNC_STAGES];
  logic [SYNC_STAGES-1:0] tx_lock_sync;
  logic [SYNC_STAGES-1:0] rx_lock_sync;
  logic [PPS_STAGES-1:0]  pps_dly;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        ref_sync[i] <= '0;
      end
      tx_lock_sync <= '0;
      rx_lock_sync <= '0;
      pps_dly      <= '0;
    end else begin
      ref_sync[0] <= i_ref_status;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        ref_sync[i] <= ref_sync[i-1];
      end
      tx_lock_sync <= {tx_lock_sync[SYNC_STAGES-2:0], i_tx_pll_lock};
      rx_lock_sync <= {rx_lock_sync[SYNC_STAGES-2:0], i_rx_pll_lock};
      // Extra stage on PPS so ntpd sees a clean edge
      pps_dly      <= {pps_dly[PPS_STAGES-2:0], i_gps_pps};
    end
  end

  assign o_ref_status  = ref_sync[SYNC_STAGES-1];
  assign o_tx_pll_lock = tx_lock_sync[SYNC_STAGES-1];
  assign o_rx_pll_lock = rx_lock_sync[SYNC_STAGES-1];
  assign o_pps_gpio    = pps_dly[PPS_STAGES-1];

  // PPS delay is exact once the chain has refilled after reset
  a_pps_delay : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (!$past(bus_rst, 1) && !$past(bus_rst, 2) && !$past(bus_rst, PPS_STAGES))
    |-> (o_pps_gpio == $past(i_gps_pps, PPS_STAGES)));

endmodule

/* hdl/button_irq_gen.sv */
//////////////////////////////
// Power switch press and release detection,
// each edge stretched into an interrupt pulse for the processor
//////////////////////////////

`timescale 1ns/1ps

module button_irq_gen
  import e31x_board_pkg::*;
(
  input  logic bus_clk,
  input  logic bus_rst,
  // Debounced switch, low while pressed
  input  logic i_onswitch_n,
  output logic o_press_irq,
  output logic o_release_irq
);

  // Two previous switch samples, [0] is the newest
  logic [1:0]             onswitch_hist;
  logic                   press_det;
  logic                   release_det;
  // Stretch shift registers
  logic [STRETCH_LEN-1:0] press_hist;
  logic [STRETCH_LEN-1:0] release_hist;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // Cleared low, so a released switch gives one release pulse
      onswitch_hist <= 2'b00;
    end else begin
      onswitch_hist <= {onswitch_hist[0], i_onswitch_n};
    end
  end

  // Edge needs two stable samples of the opposite level
  assign press_det   = ~i_onswitch_n & onswitch_hist[0] & onswitch_hist[1];
  assign release_det = i_onswitch_n & ~onswitch_hist[0] & ~onswitch_hist[1];

  // Stretch so the processor does not miss a short event
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      press_hist   <= '0;
      release_hist <= '0;
    end else begin
      press_hist   <= {press_hist[STRETCH_LEN-2:0], press_det};
      release_hist <= {release_hist[STRETCH_LEN-2:0], release_det};
    end
  end

  assign o_press_irq   = |press_hist;
  assign o_release_irq = |release_hist;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Pulse length held unless cut by reset
  a_press_len : assert property (@(posedge bus_clk) disable iff (bus_rst)
    ($fell(o_press_irq) && !$past(bus_rst)) |-> $past(o_press_irq, STRETCH_LEN));

  a_release_len : assert property (@(posedge bus_clk) disable iff (bus_rst)
    ($fell(o_release_irq) && !$past(bus_rst)) |-> $past(o_release_irq, STRETCH_LEN));

endmodule

/* hdl/frontend_pin_map.sv */
//////////////////////////////
// Registers channel GPIO and LED words onto front-end pins,
// channel 1 onto the "1" pins and channel 0 onto the "2" pins
//////////////////////////////

`timescale 1ns/1ps

module frontend_pin_map
  import e31x_frontend_pkg::*;
(
  input  logic      bus_clk,
  input  logic      bus_rst,
  // Per-channel control words
  input  fe_gpio_t  i_ch0_gpio,
  input  fe_gpio_t  i_ch1_gpio,
  input  fe_led_t   i_ch0_leds,
  input  fe_led_t   i_ch1_leds,
  // "1" pins from channel 1
  output bandsel3_t o_rx1_bandsel,
  output bandsel2_t o_rx1b_bandsel,
  output bandsel2_t o_rx1c_bandsel,
  output logic      o_tx_enable1a,
  output logic      o_tx_enable1b,
  output logic      o_vctxrx1_v1,
  output logic      o_vctxrx1_v2,
  output logic      o_vcrx1_v1,
  output logic      o_vcrx1_v2,
  // "2" pins from channel 0
  output bandsel3_t o_rx2_bandsel,
  output bandsel2_t o_rx2b_bandsel,
  output bandsel2_t o_rx2c_bandsel,
  output logic      o_tx_enable2a,
  output logic      o_tx_enable2b,
  output logic      o_vctxrx2_v1,
  output logic      o_vctxrx2_v2,
  output logic      o_vcrx2_v1,
  output logic      o_vcrx2_v2,
  // Shared transmit filter select
  output bandsel3_t o_tx_bandsel,
  // LEDs
  output logic      o_led_txrx1_tx,
  output logic      o_led_txrx1_rx,
  output logic      o_led_rx1_rx,
  output logic      o_led_txrx2_tx,
  output logic      o_led_txrx2_rx,
  output logic      o_led_rx2_rx
);

  // Per-channel transmit selects before the OR
  bandsel3_t tx1_bandsel;
  bandsel3_t tx2_bandsel;

  assign tx1_bandsel = i_ch1_gpio[FE_TX_BANDSEL_LSB +: $bits(bandsel3_t)];
  assign tx2_bandsel = i_ch0_gpio[FE_TX_BANDSEL_LSB +: $bits(bandsel3_t)];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      {o_rx1_bandsel, o_rx1b_bandsel, o_rx1c_bandsel} <= '0;
      {o_tx_enable1a, o_tx_enable1b} <= '0;
      {o_vctxrx1_v1, o_vctxrx1_v2, o_vcrx1_v1, o_vcrx1_v2} <= '0;
      {o_rx2_bandsel, o_rx2b_bandsel, o_rx2c_bandsel} <= '0;
      {o_tx_enable2a, o_tx_enable2b} <= '0;
      {o_vctxrx2_v1, o_vctxrx2_v2, o_vcrx2_v1, o_vcrx2_v2} <= '0;
      o_tx_bandsel <= '0;
      {o_led_txrx1_tx, o_led_txrx1_rx, o_led_rx1_rx} <= '0;
      {o_led_txrx2_tx, o_led_txrx2_rx, o_led_rx2_rx} <= '0;
    end else begin
      // Channel 1 to the "1" pins
      o_rx1_bandsel  <= i_ch1_gpio[FE_RX_BANDSEL_LSB +: $bits(bandsel3_t)];
      o_rx1b_bandsel <= i_ch1_gpio[FE_RXB_BANDSEL_LSB +: $bits(bandsel2_t)];
      o_rx1c_bandsel <= i_ch1_gpio[FE_RXC_BANDSEL_LSB +: $bits(bandsel2_t)];
      o_tx_enable1a  <= i_ch1_gpio[FE_TX_EN_A_BIT];
      o_tx_enable1b  <= i_ch1_gpio[FE_TX_EN_B_BIT];
      o_vctxrx1_v1   <= i_ch1_gpio[FE_VCTXRX_V1_BIT];
      o_vctxrx1_v2   <= i_ch1_gpio[FE_VCTXRX_V2_BIT];
      o_vcrx1_v1     <= i_ch1_gpio[FE_VCRX_V1_BIT];
      o_vcrx1_v2     <= i_ch1_gpio[FE_VCRX_V2_BIT];
      // Channel 0 to the "2" pins
      o_rx2_bandsel  <= i_ch0_gpio[FE_RX_BANDSEL_LSB +: $bits(bandsel3_t)];
      o_rx2b_bandsel <= i_ch0_gpio[FE_RXB_BANDSEL_LSB +: $bits(bandsel2_t)];
      o_rx2c_bandsel <= i_ch0_gpio[FE_RXC_BANDSEL_LSB +: $bits(bandsel2_t)];
      o_tx_enable2a  <= i_ch0_gpio[FE_TX_EN_A_BIT];
      o_tx_enable2b  <= i_ch0_gpio[FE_TX_EN_B_BIT];
      o_vctxrx2_v1   <= i_ch0_gpio[FE_VCTXRX_V1_BIT];
      o_vctxrx2_v2   <= i_ch0_gpio[FE_VCTXRX_V2_BIT];
      o_vcrx2_v1     <= i_ch0_gpio[FE_VCRX_V1_BIT];
      o_vcrx2_v2     <= i_ch0_gpio[FE_VCRX_V2_BIT];
      // Both channels tune together, so one select serves both
      o_tx_bandsel   <= tx1_bandsel | tx2_bandsel;
      // LEDs
      o_led_txrx1_tx <= i_ch1_leds[LED_TXRX_TX_BIT];
      o_led_txrx1_rx <= i_ch1_leds[LED_TXRX_RX_BIT];
      o_led_rx1_rx   <= i_ch1_leds[LED_RX_RX_BIT];
      o_led_txrx2_tx <= i_ch0_leds[LED_TXRX_TX_BIT];
      o_led_txrx2_rx <= i_ch0_leds[LED_TXRX_RX_BIT];
      o_led_rx2_rx   <= i_ch0_leds[LED_RX_RX_BIT];
    end
  end

endmodule

/* hdl/e31x_board_glue.sv */
//////////////////////////////
// Board glue top in bus_clk, builds the status word and
// interrupt vector and drives the front-end pins
//////////////////////////////

`timescale 1ns/1ps

module e31x_board_glue
  import e31x_board_pkg::*;
  import e31x_frontend_pkg::*;
(
  input  logic         bus_clk,
  input  logic         bus_rst,
  // Status inputs
  input  ref_status_t  i_ref_status,
  input  logic         i_tx_pll_lock,
  input  logic         i_rx_pll_lock,
  input  logic         i_gps_pps,
  output logic         o_pps_gpio,
  output status_word_t o_dboard_status,
  // Interrupt sources
  input  logic         i_onswitch_n,
  input  logic         i_pmu_irq,
  output irq_vec_t     o_irq_f2p,
  // Front-end control words
  input  fe_gpio_t     i_ch0_gpio,
  input  fe_gpio_t     i_ch1_gpio,
  input  fe_led_t      i_ch0_leds,
  input  fe_led_t      i_ch1_leds,
  // Front-end pins
  output bandsel3_t    o_rx1_bandsel,
  output bandsel2_t    o_rx1b_bandsel,
  output bandsel2_t    o_rx1c_bandsel,
  output logic         o_tx_enable1a,
  output logic         o_tx_enable1b,
  output logic         o_vctxrx1_v1,
  output logic         o_vctxrx1_v2,
  output logic         o_vcrx1_v1,
  output logic         o_vcrx1_v2,
  output bandsel3_t    o_rx2_bandsel,
  output bandsel2_t    o_rx2b_bandsel,
  output bandsel2_t    o_rx2c_bandsel,
  output logic         o_tx_enable2a,
  output logic         o_tx_enable2b,
  output logic         o_vctxrx2_v1,
  output logic         o_vctxrx2_v2,
  output logic         o_vcrx2_v1,
  output logic         o_vcrx2_v2,
  output bandsel3_t    o_tx_bandsel,
  output logic         o_led_txrx1_tx,
  output logic         o_led_txrx1_rx,
  output logic         o_led_rx1_rx,
  output logic         o_led_txrx2_tx,
  output logic         o_led_txrx2_rx,
  output logic         o_led_rx2_rx
);

  ref_status_t ref_status_sync;
  logic        tx_lock_sync;
  logic        rx_lock_sync;
  logic        press_irq;
  logic        release_irq;

  status_sync u_status_sync (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_ref_status  (i_ref_status),
    .i_tx_pll_lock (i_tx_pll_lock),
    .i_rx_pll_lock (i_rx_pll_lock),
    .i_gps_pps     (i_gps_pps),
    .o_ref_status  (ref_status_sync),
    .o_tx_pll_lock (tx_lock_sync),
    .o_rx_pll_lock (rx_lock_sync),
    .o_pps_gpio    (o_pps_gpio)
  );

  button_irq_gen u_button_irq_gen (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_onswitch_n  (i_onswitch_n),
    .o_press_irq   (press_irq),
    .o_release_irq (release_irq)
  );

  frontend_pin_map u_frontend_pin_map (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_ch0_gpio     (i_ch0_gpio),
    .i_ch1_gpio     (i_ch1_gpio),
    .i_ch0_leds     (i_ch0_leds),
    .i_ch1_leds     (i_ch1_leds),
    .o_rx1_bandsel  (o_rx1_bandsel),
    .o_rx1b_bandsel (o_rx1b_bandsel),
    .o_rx1c_bandsel (o_rx1c_bandsel),
    .o_tx_enable1a  (o_tx_enable1a),
    .o_tx_enable1b  (o_tx_enable1b),
    .o_vctxrx1_v1   (o_vctxrx1_v1),
    .o_vctxrx1_v2   (o_vctxrx1_v2),
    .o_vcrx1_v1     (o_vcrx1_v1),
    .o_vcrx1_v2     (o_vcrx1_v2),
    .o_rx2_bandsel  (o_rx2_bandsel),
    .o_rx2b_bandsel (o_rx2b_bandsel),
    .o_rx2c_bandsel (o_rx2c_bandsel),
    .o_tx_enable2a  (o_tx_enable2a),
    .o_tx_enable2b  (o_tx_enable2b),
    .o_vctxrx2_v1   (o_vctxrx2_v1),
    .o_vctxrx2_v2   (o_vctxrx2_v2),
    .o_vcrx2_v1     (o_vcrx2_v1),
    .o_vcrx2_v2     (o_vcrx2_v2),
    .o_tx_bandsel   (o_tx_bandsel),
    .o_led_txrx1_tx (o_led_txrx1_tx),
    .o_led_txrx1_rx (o_led_txrx1_rx),
    .o_led_rx1_rx   (o_led_rx1_rx),
    .o_led_txrx2_tx (o_led_txrx2_tx),
    .o_led_txrx2_rx (o_led_txrx2_rx),
    .o_led_rx2_rx   (o_led_rx2_rx)
  );

  //////////////////////////////
  // Status word and interrupts
  //////////////////////////////

  // Unused status bits read as zero
  always_comb begin
    o_dboard_status = '0;
    o_dboard_status[STAT_REF_LSB +: $bits(ref_status_t)] = ref_status_sync;
    o_dboard_status[STAT_TX_LOCK_BIT] = tx_lock_sync;
    o_dboard_status[STAT_RX_LOCK_BIT] = rx_lock_sync;
  end

  // PMU interrupt passes straight through
  always_comb begin
    o_irq_f2p = '0;
    o_irq_f2p[IRQ_PRESS_BIT]   = press_irq;
    o_irq_f2p[IRQ_RELEASE_BIT] = release_irq;
    o_irq_f2p[IRQ_PMU_BIT]     = i_pmu_irq;
  end

endmodule

/* verif/tb_e31x_board_glue.sv */
//////////////////////////////
// Self-checking testbench for the board glue top,
// random stimulus with concurrent checks and a watchdog
//////////////////////////////

`timescale 1ns/1ps

module tb_e31x_board_glue
  import e31x_board_pkg::*;
  import e31x_frontend_pkg::*;
();

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

  logic         bus_clk;
  logic         bus_rst;
  ref_status_t  i_ref_status;
  logic         i_tx_pll_lock;
  logic         i_rx_pll_lock;
  logic         i_gps_pps;
  logic         o_pps_gpio;
  status_word_t o_dboard_status;
  logic         i_onswitch_n;
  logic         i_pmu_irq;
  irq_vec_t     o_irq_f2p;
  fe_gpio_t     i_ch0_gpio;
  fe_gpio_t     i_ch1_gpio;
  fe_led_t      i_ch0_leds;
  fe_led_t      i_ch1_leds;
  bandsel3_t    o_rx1_bandsel;
  bandsel3_t    o_rx2_bandsel;
  bandsel3_t    o_tx_bandsel;
  bandsel2_t    o_rx1b_bandsel;
  bandsel2_t    o_rx1c_bandsel;
  bandsel2_t    o_rx2b_bandsel;
  bandsel2_t    o_rx2c_bandsel;
  logic         o_tx_enable1a;
  logic         o_tx_enable1b;
  logic         o_tx_enable2a;
  logic         o_tx_enable2b;
  logic         o_vctxrx1_v1;
  logic         o_vctxrx1_v2;
  logic         o_vcrx1_v1;
  logic         o_vcrx1_v2;
  logic         o_vctxrx2_v1;
  logic         o_vctxrx2_v2;
  logic         o_vcrx2_v1;
  logic         o_vcrx2_v2;
  logic         o_led_txrx1_tx;
  logic         o_led_txrx1_rx;
  logic         o_led_rx1_rx;
  logic         o_led_txrx2_tx;
  logic         o_led_txrx2_rx;
  logic         o_led_rx2_rx;

  integer       seed = 10047;

  // Reference model state
  logic [7:0]   live_cycles;
  logic [1:0]   sw_prev;
  logic [3:0]   press_left;
  logic [3:0]   release_left;
  ref_status_t  ref_d1;
  ref_status_t  ref_d2;
  logic [1:0]   tx_d;
  logic [1:0]   rx_d;
  logic [2:0]   pps_d;
  fe_gpio_t     gpio0_d;
  fe_gpio_t     gpio1_d;
  fe_led_t      leds0_d;
  fe_led_t      leds1_d;
  status_word_t exp_status;
  logic [34:0]  exp_pins;
  logic [34:0]  fe_pins_act;

  e31x_board_glue DUT (.*);

  initial begin
    bus_clk = 1'b0;
    forever #20 bus_clk = ~bus_clk;
  end

  //////////////////////////////
  // Expected values
  //////////////////////////////

  // Status word layout
  function automatic status_word_t build_status(input ref_status_t r, input logic tx,
                                                input logic rx);
    status_word_t w;
    w       = '0;
    w[11:8] = r;
    w[7]    = tx;
    w[6]    = rx;
    return w;
  endfunction

  // Pin order matches fe_pins_act, channel 1 on the "1" pins
  function automatic logic [34:0] build_pins(input fe_gpio_t g0, input fe_gpio_t g1,
                                             input fe_led_t l0, input fe_led_t l1);
    return {g1[5:3], g1[7:6], g1[9:8], g1[10], g1[11], g1[13], g1[12], g1[15], g1[14],
            g0[5:3], g0[7:6], g0[9:8], g0[10], g0[11], g0[13], g0[12], g0[15], g0[14],
            g1[2:0] | g0[2:0],
            l1[1], l1[0], l1[2], l0[1], l0[0], l0[2]};
  endfunction

  assign exp_status  = build_status(ref_d2, tx_d[1], rx_d[1]);
  assign exp_pins    = build_pins(gpio0_d, gpio1_d, leds0_d, leds1_d);
  assign fe_pins_act = {o_rx1_bandsel, o_rx1b_bandsel, o_rx1c_bandsel,
                        o_tx_enable1a, o_tx_enable1b, o_vctxrx1_v1, o_vctxrx1_v2,
                        o_vcrx1_v1, o_vcrx1_v2,
                        o_rx2_bandsel, o_rx2b_bandsel, o_rx2c_bandsel,
                        o_tx_enable2a, o_tx_enable2b, o_vctxrx2_v1, o_vctxrx2_v2,
                        o_vcrx2_v1, o_vcrx2_v2,
                        o_tx_bandsel,
                        o_led_txrx1_tx, o_led_txrx1_rx, o_led_rx1_rx,
                        o_led_txrx2_tx, o_led_txrx2_rx, o_led_rx2_rx};

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      live_cycles  <= 8'd0;
      // Switch samples start low, as after reset in the DUT
      sw_prev      <= 2'b00;
      press_left   <= 4'd0;
      release_left <= 4'd0;
    end else begin
      if (live_cycles != 8'hff) begin
        live_cycles <= live_cycles + 8'd1;
      end
      sw_prev <= {sw_prev[0], i_onswitch_n};
      // Edge reloads the pulse counter
      if (!i_onswitch_n && sw_prev == 2'b11) begin
        press_left <= 4'(STRETCH_LEN);
      end else if (press_left != 4'd0) begin
        press_left <= press_left - 4'd1;
      end
      if (i_onswitch_n && sw_prev == 2'b00) begin
        release_left <= 4'(STRETCH_LEN);
      end else if (release_left != 4'd0) begin
        release_left <= release_left - 4'd1;
      end
    end
    // Input delay lines
    ref_d1  <= i_ref_status;
    ref_d2  <= ref_d1;
    tx_d    <= {tx_d[0], i_tx_pll_lock};
    rx_d    <= {rx_d[0], i_rx_pll_lock};
    pps_d   <= {pps_d[1:0], i_gps_pps};
    gpio0_d <= i_ch0_gpio;
    gpio1_d <= i_ch1_gpio;
    leds0_d <= i_ch0_leds;
    leds1_d <= i_ch1_leds;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
    $display("Errors found");
    $fatal(1, "check %s failed", name);
  endtask

  a_status_word : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (live_cycles >= 8'd2) |-> (o_dboard_status == exp_status))
    else report_mismatch("status", 64'($sampled(exp_status)), 64'($sampled(o_dboard_status)));

  a_pps_delay : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (live_cycles >= 8'd3) |-> (o_pps_gpio == pps_d[2]))
    else report_mismatch("pps", 64'($sampled(pps_d[2])), 64'($sampled(o_pps_gpio)));

  a_frontend_pins : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (live_cycles >= 8'd1) |-> (fe_pins_act == exp_pins))
    else report_mismatch("frontend", 64'($sampled(exp_pins)), 64'($sampled(fe_pins_act)));

  // Pins cleared by reset
  a_pins_after_reset : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (live_cycles == 8'd0) |-> (fe_pins_act == '0))
    else report_mismatch("reset pins", 64'd0, 64'($sampled(fe_pins_act)));

  a_press_irq : assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_irq_f2p[IRQ_PRESS_BIT] == (press_left != 4'd0))
    else report_mismatch("press", 64'($sampled(press_left != 4'd0)),
                         64'($sampled(o_irq_f2p[IRQ_PRESS_BIT])));

  a_release_irq : assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_irq_f2p[IRQ_RELEASE_BIT] == (release_left != 4'd0))
    else report_mismatch("release", 64'($sampled(release_left != 4'd0)),
                         64'($sampled(o_irq_f2p[IRQ_RELEASE_BIT])));

  a_pmu_irq : assert property (@(posedge bus_clk) o_irq_f2p[IRQ_PMU_BIT] == i_pmu_irq)
    else report_mismatch("pmu irq", 64'($sampled(i_pmu_irq)),
                         64'($sampled(o_irq_f2p[IRQ_PMU_BIT])));

  a_irq_unused : assert property (@(posedge bus_clk)
    (o_irq_f2p[0] == 1'b0) && (o_irq_f2p[15:4] == 12'd0))
    else report_mismatch("irq unused", 64'd0, 64'($sampled(o_irq_f2p & 16'hfff1)));

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Holds of 2 to 5 cycles, short ones land inside the stretch window
  task automatic run_button_test();
    logic [31:0] rnd;
    for (int r = 0; r < 6; r++) begin
      rnd = $random(seed);
      repeat (2 + rnd[1:0]) @(posedge bus_clk);
      i_onswitch_n <= 1'b0;
      repeat (2 + rnd[3:2]) @(posedge bus_clk);
      i_onswitch_n <= 1'b1;
    end
    repeat (STRETCH_LEN + 4) @(posedge bus_clk);
  endtask

  task automatic run_status_test();
    logic [31:0] rnd;
    for (int n = 0; n < 20; n++) begin
      rnd = $random(seed);
      @(posedge bus_clk);
      i_ref_status  <= rnd[3:0];
      i_tx_pll_lock <= rnd[4];
      i_rx_pll_lock <= rnd[5];
      repeat (2 + rnd[7:6]) @(posedge bus_clk);
    end
  endtask

  // Random toggling, about one edge in four cycles
  task automatic run_pps_test();
    logic [31:0] rnd;
    for (int n = 0; n < 80; n++) begin
      rnd = $random(seed);
      @(posedge bus_clk);
      if (rnd[1:0] == 2'b00) begin
        i_gps_pps <= ~i_gps_pps;
      end
    end
  endtask

  task automatic run_frontend_test();
    logic [31:0] rnd;
    logic [31:0] rnd_leds;
    for (int n = 0; n < 40; n++) begin
      rnd      = $random(seed);
      rnd_leds = $random(seed);
      @(posedge bus_clk);
      i_ch0_gpio <= rnd[15:0];
      i_ch1_gpio <= rnd[31:16];
      i_ch0_leds <= rnd_leds[2:0];
      i_ch1_leds <= rnd_leds[5:3];
    end
  endtask

  task automatic run_pmu_test();
    logic [31:0] rnd;
    for (int n = 0; n < 20; n++) begin
      rnd = $random(seed);
      @(posedge bus_clk);
      i_pmu_irq <= rnd[0];
    end
  endtask

  initial begin
    bus_rst       = 1'b1;
    i_ref_status  = '0;
    i_tx_pll_lock = 1'b0;
    i_rx_pll_lock = 1'b0;
    i_gps_pps     = 1'b0;
    // Switch up, so one release pulse follows reset
    i_onswitch_n  = 1'b1;
    i_pmu_irq     = 1'b0;
    // Front-end words all ones during reset, so cleared pins stand out
    i_ch0_gpio    = '1;
    i_ch1_gpio    = '1;
    i_ch0_leds    = '1;
    i_ch1_leds    = '1;
    repeat (2) @(posedge bus_clk);
    bus_rst <= 1'b0;
    run_button_test();
    run_status_test();
    run_pps_test();
    run_frontend_test();
    run_pmu_test();
    repeat (4) @(posedge bus_clk);
    $display("No errors");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

/* compile.f */
hdl/e31x_board_pkg.sv
hdl/e31x_frontend_pkg.sv
hdl/status_sync.sv
hdl/button_irq_gen.sv
hdl/frontend_pin_map.sv
hdl/e31x_board_glue.sv
verif/tb_e31x_board_glue.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -j 0 --top-module tb_e31x_board_glue \
  -f compile.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
grep -q "No errors" sim.log
